// ==== compile.f ====
hw/proc_isa_pkg.sv
hw/proc_pipe_pkg.sv
hw/pipe_reg.sv
hw/fetch.sv
hw/decode.sv
hw/hazard_detect.sv
hw/execute.sv
hw/memory_stage.sv
hw/proc.sv
verif/proc_tb.sv

// ==== Bender.yml ====
package:
  name: proc

sources:
  - files:
      - hw/proc_isa_pkg.sv
      - hw/proc_pipe_pkg.sv
      - hw/pipe_reg.sv
      - hw/fetch.sv
      - hw/decode.sv
      - hw/hazard_detect.sv
      - hw/execute.sv
      - hw/memory_stage.sv
      - hw/proc.sv
  - target: test
    files:
      - verif/proc_tb.sv

// ==== verif/proc_tb.sv ====
`timescale 1ns/1ps

module proc_tb;

   localparam logic [31:0] reset_pc = 32'h0000_0100;
   localparam int num_instrs = 38;
   localparam int num_writes = 12;
   localparam int ram_words = 64;
   // Five cycles per instruction is far above the worst stall and flush cost
   localparam int max_cycles = num_instrs * 5 + 10;
   localparam int drain_cycles = 8;

   // Values the program leaves in r1 to r10
   localparam logic [31:0] v1 = 32'h0000_00f0;
   localparam logic [31:0] v2 = v1 + 32'h0000_0033;
   localparam logic [31:0] v3 = v1 + v2;
   localparam logic [31:0] v4 = v3 - v1;
   localparam logic [31:0] v5 = v3 & v2;
   localparam logic [31:0] v6 = v4 | v3;
   localparam logic [31:0] v7 = v6 ^ v5;
   localparam logic [31:0] v8 = 32'hffff_fffb;
   localparam logic [31:0] v9 = ($signed(v8) < $signed(v7)) ? 32'd1 : 32'd0;
   localparam logic [31:0] v10 = ($signed(v7) < $signed(v8)) ? 32'd1 : 32'd0;

   logic        clk = 1'b0;
   logic        rst;
   logic [31:0] instruction;
   logic [31:0] data_mem_data;
   logic [31:0] instr_addr;
   logic [31:0] data_mem_addr;
   logic [31:0] data_mem_write_data;
   logic [3:0]  data_mem_wr;
   logic [3:0]  data_mem_en;
   logic        HALTED;

   logic [31:0] rom [num_instrs];
   logic [31:0] ram [ram_words];
   logic [31:0] rom_idx;
   logic [31:0] lane_mask;
   logic [31:0] exp_addr [num_writes];
   logic [31:0] exp_data [num_writes];
   string       exp_name [num_writes];
   int          write_count = 0;
   int          check_count = 0;
   int          error_count = 0;
   int          cycle_count = 0;
   logic        rst_prev = 1'b0;
   logic        halted_seen = 1'b0;

   proc #(.num_regs(32), .reset_pc(reset_pc)) proc_i (
      .data_mem_addr(data_mem_addr), .data_mem_write_data(data_mem_write_data),
      .data_mem_wr(data_mem_wr), .data_mem_en(data_mem_en),
      .instr_addr(instr_addr), .HALTED(HALTED),
      .clk(clk), .rst(rst), .data_mem_data(data_mem_data), .instruction(instruction)
   );

   always #50 clk = ~clk;

   // Instruction ROM, combinational read
   assign rom_idx = (instr_addr - reset_pc) >> 2;
   assign instruction = (rom_idx < num_instrs) ? rom[rom_idx] : proc_isa_pkg::nop_instr;

   // Data RAM, one-cycle read, byte-lane writes
   assign lane_mask = {{8{data_mem_wr[3]}}, {8{data_mem_wr[2]}},
                       {8{data_mem_wr[1]}}, {8{data_mem_wr[0]}}};

   always @(posedge clk) begin
      if (data_mem_en != 4'h0) begin
         data_mem_data <= ram[data_mem_addr[7:2]];
      end
      if (data_mem_wr != 4'h0) begin
         ram[data_mem_addr[7:2]] <= (ram[data_mem_addr[7:2]] & ~lane_mask) |
                                    (data_mem_write_data & lane_mask);
      end
   end

   function automatic logic [31:0] fill_word(input int idx);
      return 32'hc0de_0000 + (idx << 2);
   endfunction

   function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt);
      return {6'(proc_isa_pkg::op_rtype), rs, rt, rd, 5'd0, funct};
   endfunction

   function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // Stores to these addresses sit in branch shadows or after HALT
   function automatic logic in_skipped_range(input logic [31:0] addr);
      return (addr >= 32'h30 && addr <= 32'h38) || (addr >= 32'h40 && addr <= 32'h48) ||
             (addr == 32'h50);
   endfunction

   task automatic compare_word(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      check_count++;
      assert (actual === expected) else begin
         error_count++;
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      check_count++;
      assert (cond === 1'b1) else begin
         error_count++;
         $display("ERROR: %s", what);
      end
   endtask

   task automatic set_write(input int idx, input string name, input logic [31:0] addr,
                            input logic [31:0] data);
      exp_name[idx] = name;
      exp_addr[idx] = addr;
      exp_data[idx] = data;
   endtask

   task automatic load_program();
      rom[0]  = enc_i(proc_isa_pkg::op_addi, 5'd0, 5'd1, 16'h00f0);
      rom[1]  = enc_i(proc_isa_pkg::op_addi, 5'd1, 5'd2, 16'h0033);
      rom[2]  = enc_r(proc_isa_pkg::funct_add, 5'd3, 5'd1, 5'd2);
      rom[3]  = enc_r(proc_isa_pkg::funct_sub, 5'd4, 5'd3, 5'd1);
      rom[4]  = enc_r(proc_isa_pkg::funct_and, 5'd5, 5'd3, 5'd2);
      rom[5]  = enc_r(proc_isa_pkg::funct_or, 5'd6, 5'd4, 5'd3);
      rom[6]  = enc_r(proc_isa_pkg::funct_xor, 5'd7, 5'd6, 5'd5);
      rom[7]  = enc_i(proc_isa_pkg::op_addi, 5'd0, 5'd8, 16'hfffb);
      rom[8]  = enc_r(proc_isa_pkg::funct_slt, 5'd9, 5'd8, 5'd7);
      rom[9]  = enc_r(proc_isa_pkg::funct_slt, 5'd10, 5'd7, 5'd8);
      rom[10] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd10, 16'h0018);
      rom[11] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd9, 16'h0014);
      rom[12] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd3, 16'h0000);
      rom[13] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd4, 16'h0004);
      rom[14] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd5, 16'h0008);
      rom[15] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd6, 16'h000c);
      rom[16] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd7, 16'h0010);
      rom[17] = enc_i(proc_isa_pkg::op_addi, 5'd0, 5'd11, 16'h0080);
      rom[18] = enc_i(proc_isa_pkg::op_sw, 5'd11, 5'd2, 16'h0004);
      // Load-use pairs, the second one feeds store data
      rom[19] = enc_i(proc_isa_pkg::op_lw, 5'd0, 5'd12, 16'h0020);
      rom[20] = enc_r(proc_isa_pkg::funct_add, 5'd13, 5'd12, 5'd1);
      rom[21] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd13, 16'h0024);
      rom[22] = enc_i(proc_isa_pkg::op_lw, 5'd0, 5'd14, 16'h0084);
      rom[23] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd14, 16'h0028);
      rom[24] = enc_r(proc_isa_pkg::funct_sub, 5'd15, 5'd1, 5'd1);
      rom[25] = enc_i(proc_isa_pkg::op_beqz, 5'd15, 5'd0, 16'd3);
      rom[26] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd1, 16'h0030);
      rom[27] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd1, 16'h0034);
      rom[28] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd1, 16'h0038);
      rom[29] = enc_i(proc_isa_pkg::op_bnez, 5'd15, 5'd0, 16'd3);
      rom[30] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd2, 16'h003c);
      rom[31] = enc_i(proc_isa_pkg::op_j, 5'd0, 5'd0, 16'd3);
      rom[32] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd1, 16'h0040);
      rom[33] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd1, 16'h0044);
      rom[34] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd1, 16'h0048);
      rom[35] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd8, 16'h004c);
      rom[36] = enc_i(proc_isa_pkg::op_halt, 5'd0, 5'd0, 16'd0);
      rom[37] = enc_i(proc_isa_pkg::op_sw, 5'd0, 5'd1, 16'h0050);
   endtask

   task automatic load_expected();
      set_write(0, "fwd_slt_low", 32'h18, v10);
      set_write(1, "fwd_slt_high", 32'h14, v9);
      set_write(2, "fwd_add", 32'h00, v3);
      set_write(3, "fwd_sub", 32'h04, v4);
      set_write(4, "fwd_and", 32'h08, v5);
      set_write(5, "fwd_or", 32'h0c, v6);
      set_write(6, "fwd_xor", 32'h10, v7);
      set_write(7, "fwd_base", 32'h84, v2);
      set_write(8, "load_use_add", 32'h24, fill_word(8) + v1);
      set_write(9, "load_use_store", 32'h28, v2);
      set_write(10, "bnez_not_taken", 32'h3c, v2);
      set_write(11, "jump_target", 32'h4c, v8);
   endtask

   // Monitor on the falling edge, where DUT outputs are settled
   always @(negedge clk) begin
      if (rst || rst_prev) begin
         compare_word("reset_instr_addr", reset_pc, instr_addr);
         compare_word("reset_mem_wr", 32'd0, {28'd0, data_mem_wr});
         compare_word("reset_mem_en", 32'd0, {28'd0, data_mem_en});
         compare_word("reset_halted", 32'd0, {31'd0, HALTED});
      end
      rst_prev = rst;
      if (halted_seen) begin
         check_true(HALTED, "HALTED dropped after it rose");
      end
      if (HALTED === 1'b1) begin
         halted_seen = 1'b1;
      end
      if (!rst && data_mem_wr !== 4'h0) begin
         check_true(!HALTED, $sformatf("data memory write at %h after HALTED", data_mem_addr));
         check_true(!in_skipped_range(data_mem_addr),
                    $sformatf("squashed or post-HALT store wrote address %h", data_mem_addr));
         compare_word("store_lanes", 32'h0000_00ff, {24'd0, data_mem_wr, data_mem_en});
         if (write_count < num_writes) begin
            compare_word({exp_name[write_count], "_addr"}, exp_addr[write_count],
                         data_mem_addr);
            compare_word({exp_name[write_count], "_data"}, exp_data[write_count],
                         data_mem_write_data);
         end else begin
            check_true(1'b0, $sformatf("unexpected extra write at %h", data_mem_addr));
         end
         write_count++;
      end
   end

   initial begin
      int i;
      rst = 1'b1;
      data_mem_data = 32'd0;
      load_program();
      load_expected();
      for (i = 0; i < ram_words; i++) begin
         ram[i] = fill_word(i);
      end
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      while (HALTED !== 1'b1 && cycle_count < max_cycles) begin
         @(posedge clk);
         cycle_count++;
      end
      if (HALTED !== 1'b1) begin
         error_count++;
         $display("ERROR: timeout, HALTED not raised within %0d cycles", max_cycles);
      end else begin
         // Let any stray write or a falling HALTED show up
         repeat (drain_cycles) @(posedge clk);
      end
      compare_word("write_count", num_writes, write_count);
      $display("checks: %0d, errors: %0d, writes: %0d, cycles: %0d",
               check_count, error_count, write_count, cycle_count);
      if (error_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== hw/proc.sv ====
`timescale 1ns/1ps

module proc #(
   parameter int          num_regs = 32,
   parameter logic [31:0] reset_pc = 32'h0000_0000
) (
   // Outputs
   output logic [31:0] data_mem_addr,
   output logic [31:0] data_mem_write_data,
   output logic [3:0]  data_mem_wr,
   output logic [3:0]  data_mem_en,
   output logic [31:0] instr_addr,
   output logic        HALTED,
   // Inputs
   input  logic        clk,
   input  logic        rst,
   input  logic [31:0] data_mem_data,
   input  logic [31:0] instruction
);

   // IF/ID
   logic [31:0] id_instr;
   logic [31:0] id_pc_4;
   logic        id_valid;

   // Decode outputs
   proc_pipe_pkg::id_ex_t  id_payload;
   logic [4:0]             id_rs;
   logic [4:0]             id_rt;
   logic                   id_uses_rt;
   logic [31:0]            wb_write_data;

   // Stage registers and stage results
   proc_pipe_pkg::id_ex_t   ex_data;
   logic                    ex_valid;
   proc_pipe_pkg::ex_mem_t  ex_result;
   proc_pipe_pkg::ex_mem_t  mem_data;
   logic                    mem_valid;
   proc_pipe_pkg::mem_wb_t  mem_result;
   proc_pipe_pkg::mem_wb_t  wb_data;
   logic                    wb_valid;

   // Control
   logic                    stall_id;
   logic                    take_branch;
   logic [31:0]             branch_addr;
   proc_pipe_pkg::fwd_sel_t fwd_a;
   proc_pipe_pkg::fwd_sel_t fwd_b;

   // HALT in WB freezes MEM/WB, so the flag sticks
   assign HALTED = wb_valid && wb_data.halt;

   fetch #(.reset_pc(reset_pc)) fetch_i (
      .clk(clk), .rst(rst), .stall(stall_id),
      .take_branch(take_branch), .branch_addr(branch_addr),
      .instruction(instruction), .instr_addr(instr_addr),
      .id_instr(id_instr), .id_pc_4(id_pc_4), .id_valid(id_valid)
   );

   decode #(.num_regs(num_regs)) decode_i (
      .clk(clk), .rst(rst), .instr(id_instr), .pc_4(id_pc_4), .valid(id_valid),
      .wb_valid(wb_valid), .wb_data_in(wb_data), .data_mem_data(data_mem_data),
      .id_ex(id_payload), .rs(id_rs), .rt(id_rt), .uses_rt(id_uses_rt),
      .wb_write_data(wb_write_data)
   );

   // Load-use bubble enters here
   pipe_reg #(.payload_t(proc_pipe_pkg::id_ex_t)) id_ex_reg (
      .clk(clk), .rst(rst), .stall(1'b0), .flush(take_branch || stall_id),
      .in_valid(id_valid), .in_data(id_payload),
      .out_valid(ex_valid), .out_data(ex_data)
   );

   hazard_detect #(.num_regs(num_regs)) hazard_i (
      .id_rs(id_rs), .id_rt(id_rt), .id_uses_rt(id_uses_rt), .id_valid(id_valid),
      .ex_data(ex_data), .ex_valid(ex_valid), .mem_data(mem_data), .mem_valid(mem_valid),
      .wb_data(wb_data), .wb_valid(wb_valid),
      .stall_id(stall_id), .fwd_a(fwd_a), .fwd_b(fwd_b)
   );

   execute execute_i (
      .id_ex(ex_data), .fwd_a(fwd_a), .fwd_b(fwd_b),
      .mem_alu(mem_data.alu_result), .wb_write_data(wb_write_data),
      .ex_mem(ex_result)
   );

   pipe_reg #(.payload_t(proc_pipe_pkg::ex_mem_t)) ex_mem_reg (
      .clk(clk), .rst(rst), .stall(1'b0), .flush(take_branch),
      .in_valid(ex_valid), .in_data(ex_result),
      .out_valid(mem_valid), .out_data(mem_data)
   );

   // Branches resolve here
   memory_stage memory_i (
      .ex_mem(mem_data), .valid(mem_valid),
      .data_mem_addr(data_mem_addr), .data_mem_write_data(data_mem_write_data),
      .data_mem_wr(data_mem_wr), .data_mem_en(data_mem_en),
      .take_branch(take_branch), .branch_addr(branch_addr), .mem_wb(mem_result)
   );

   pipe_reg #(.payload_t(proc_pipe_pkg::mem_wb_t)) mem_wb_reg (
      .clk(clk), .rst(rst), .stall(HALTED), .flush(1'b0),
      .in_valid(mem_valid), .in_data(mem_result),
      .out_valid(wb_valid), .out_data(wb_data)
   );

endmodule

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
   input  proc_pipe_pkg::ex_mem_t ex_mem,
   input  logic                   valid,
   output logic [31:0]            data_mem_addr,
   output logic [31:0]            data_mem_write_data,
   output logic [3:0]             data_mem_wr,
   output logic [3:0]             data_mem_en,
   output logic                   take_branch,
   output logic [31:0]            branch_addr,
   output proc_pipe_pkg::mem_wb_t mem_wb
);

   logic do_read;
   logic do_write;

   assign do_read  = valid && ex_mem.mem_rd;
   assign do_write = valid && ex_mem.mem_wr;

   // Word accesses only, all four lanes
   assign data_mem_addr       = ex_mem.alu_result;
   assign data_mem_write_data = ex_mem.store_data;
   assign data_mem_en         = (do_read || do_write) ? 4'hf : 4'h0;
   assign data_mem_wr         = do_write ? 4'hf : 4'h0;

   // Branch resolution on the forwarded rs value
   always_comb begin
      case (ex_mem.br_kind)
         proc_pipe_pkg::br_eqz:  take_branch = valid && (ex_mem.rs_val == 32'd0);
         proc_pipe_pkg::br_nez:  take_branch = valid && (ex_mem.rs_val != 32'd0);
         proc_pipe_pkg::br_jump: take_branch = valid;
         default:                take_branch = 1'b0;
      endcase
   end

   assign branch_addr = ex_mem.br_target;

   always_comb begin
      mem_wb            = '0;
      mem_wb.alu_result = ex_mem.alu_result;
      mem_wb.rd         = ex_mem.rd;
      mem_wb.reg_wr     = ex_mem.reg_wr;
      mem_wb.wb_src     = ex_mem.wb_src;
      mem_wb.halt       = ex_mem.halt;
   end

endmodule

// ==== hw/execute.sv ====
`timescale 1ns/1ps

module execute (
   input  proc_pipe_pkg::id_ex_t    id_ex,
   input  proc_pipe_pkg::fwd_sel_t  fwd_a,
   input  proc_pipe_pkg::fwd_sel_t  fwd_b,
   input  logic [31:0]              mem_alu,
   input  logic [31:0]              wb_write_data,
   output proc_pipe_pkg::ex_mem_t   ex_mem
);

   logic [31:0] opnd_a;
   logic [31:0] opnd_b;
   logic [31:0] alu_b;
   logic [31:0] alu_out;

   // Forwarding muxes
   always_comb begin
      case (fwd_a)
         proc_pipe_pkg::fwd_mem: opnd_a = mem_alu;
         proc_pipe_pkg::fwd_wb:  opnd_a = wb_write_data;
         default:                opnd_a = id_ex.op_a;
      endcase
      case (fwd_b)
         proc_pipe_pkg::fwd_mem: opnd_b = mem_alu;
         proc_pipe_pkg::fwd_wb:  opnd_b = wb_write_data;
         default:                opnd_b = id_ex.op_b;
      endcase
   end

   assign alu_b = id_ex.alusrc ? id_ex.imm : opnd_b;

   always_comb begin
      case (id_ex.alu_op)
         proc_isa_pkg::alu_sub: alu_out = opnd_a - alu_b;
         proc_isa_pkg::alu_and: alu_out = opnd_a & alu_b;
         proc_isa_pkg::alu_or:  alu_out = opnd_a | alu_b;
         proc_isa_pkg::alu_xor: alu_out = opnd_a ^ alu_b;
         proc_isa_pkg::alu_slt: alu_out = {31'd0, $signed(opnd_a) < $signed(alu_b)};
         default:               alu_out = opnd_a + alu_b;
      endcase
   end

   always_comb begin
      ex_mem            = '0;
      ex_mem.alu_result = alu_out;
      ex_mem.store_data = opnd_b;
      ex_mem.rd         = id_ex.rd;
      ex_mem.reg_wr     = id_ex.reg_wr;
      ex_mem.wb_src     = id_ex.wb_src;
      ex_mem.mem_rd     = id_ex.mem_rd;
      ex_mem.mem_wr     = id_ex.mem_wr;
      ex_mem.br_kind    = id_ex.br_kind;
      ex_mem.rs_val     = opnd_a;
      // Word offset relative to PC+4
      ex_mem.br_target  = id_ex.pc_4 + {id_ex.imm[29:0], 2'b00};
      ex_mem.halt       = id_ex.halt;
   end

endmodule

// ==== hw/hazard_detect.sv ====
`timescale 1ns/1ps

module hazard_detect #(
   parameter int num_regs = 32
) (
   input  logic                    [4:0] id_rs,
   input  logic                    [4:0] id_rt,
   input  logic                          id_uses_rt,
   input  logic                          id_valid,
   input  proc_pipe_pkg::id_ex_t         ex_data,
   input  logic                          ex_valid,
   input  proc_pipe_pkg::ex_mem_t        mem_data,
   input  logic                          mem_valid,
   input  proc_pipe_pkg::mem_wb_t        wb_data,
   input  logic                          wb_valid,
   output logic                          stall_id,
   output proc_pipe_pkg::fwd_sel_t       fwd_a,
   output proc_pipe_pkg::fwd_sel_t       fwd_b
);

   // Register numbers compare at register file width
   localparam int idx_w = $clog2(num_regs);

   logic [idx_w-1:0] ex_rd;
   logic [idx_w-1:0] mem_rd;
   logic [idx_w-1:0] wb_rd;
   logic             ex_load;
   logic             mem_fwd_ok;
   logic             wb_fwd_ok;

   assign ex_rd  = ex_data.rd[idx_w-1:0];
   assign mem_rd = mem_data.rd[idx_w-1:0];
   assign wb_rd  = wb_data.rd[idx_w-1:0];

   // Load in EX feeding the instruction in ID
   assign ex_load  = ex_valid && ex_data.mem_rd && ex_data.reg_wr && (ex_rd != '0);
   assign stall_id = id_valid && ex_load &&
                     ((ex_rd == id_rs[idx_w-1:0]) ||
                      (id_uses_rt && (ex_rd == id_rt[idx_w-1:0])));

   // Load data is not ready in MEM
   assign mem_fwd_ok = mem_valid && mem_data.reg_wr && (mem_rd != '0) &&
                       (mem_data.wb_src == proc_pipe_pkg::wb_alu);
   assign wb_fwd_ok  = wb_valid && wb_data.reg_wr && (wb_rd != '0);

   // Younger producer wins
   function automatic proc_pipe_pkg::fwd_sel_t pick(input logic [4:0] src);
      if (mem_fwd_ok && (mem_rd == src[idx_w-1:0])) begin
         return proc_pipe_pkg::fwd_mem;
      end else if (wb_fwd_ok && (wb_rd == src[idx_w-1:0])) begin
         return proc_pipe_pkg::fwd_wb;
      end
      return proc_pipe_pkg::fwd_reg;
   endfunction

   always_comb begin
      fwd_a = pick(ex_data.rs);
      fwd_b = pick(ex_data.rt);
   end

endmodule

// ==== hw/decode.sv ====
`timescale 1ns/1ps

module decode #(
   parameter int num_regs = 32
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [31:0]            instr,
   input  logic [31:0]            pc_4,
   input  logic                   valid,
   input  logic                   wb_valid,
   input  proc_pipe_pkg::mem_wb_t wb_data_in,
   input  logic [31:0]            data_mem_data,
   output proc_pipe_pkg::id_ex_t  id_ex,
   output logic [4:0]             rs,
   output logic [4:0]             rt,
   output logic                   uses_rt,
   output logic [31:0]            wb_write_data
);

   localparam int idx_w = $clog2(num_regs);

   logic [31:0]                regs [num_regs];
   logic [idx_w-1:0]           wr_idx;
   logic                       wr_en;
   proc_isa_pkg::opcode_t      opcode;
   proc_isa_pkg::funct_t       funct;

   assign opcode  = proc_isa_pkg::opcode_t'(instr[proc_isa_pkg::op_msb:proc_isa_pkg::op_lsb]);
   assign funct   = proc_isa_pkg::funct_t'(instr[5:0]);
   assign rs      = instr[proc_isa_pkg::rs_lsb +: 5];
   assign rt      = instr[proc_isa_pkg::rt_lsb +: 5];
   assign uses_rt = (opcode == proc_isa_pkg::op_rtype) || (opcode == proc_isa_pkg::op_sw);

   // Writeback value, load data shows up during WB
   assign wb_write_data = (wb_data_in.wb_src == proc_pipe_pkg::wb_mem) ? data_mem_data
                                                                        : wb_data_in.alu_result;
   assign wr_idx = wb_data_in.rd[idx_w-1:0];
   assign wr_en  = !rst && wb_valid && wb_data_in.reg_wr && (wr_idx != '0);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         regs[wr_idx] <= wb_write_data;
      end
   end

   // r0 reads zero; same-cycle write bypasses the array
   function automatic logic [31:0] read_reg(input logic [4:0] idx);
      logic [idx_w-1:0] sel;
      sel = idx[idx_w-1:0];
      if (sel == '0) begin
         return 32'd0;
      end else if (wr_en && (wr_idx == sel)) begin
         return wb_write_data;
      end
      return regs[sel];
   endfunction

   always_comb begin
      id_ex         = '0;
      id_ex.op_a    = read_reg(rs);
      id_ex.op_b    = read_reg(rt);
      id_ex.imm     = {{16{instr[15]}}, instr[15:0]};
      id_ex.rs      = rs;
      id_ex.rt      = rt;
      id_ex.pc_4    = pc_4;
      id_ex.alu_op  = proc_isa_pkg::alu_add;
      id_ex.wb_src  = proc_pipe_pkg::wb_none;
      id_ex.br_kind = proc_pipe_pkg::br_none;
      case (opcode)
         proc_isa_pkg::op_rtype: begin
            id_ex.rd     = instr[proc_isa_pkg::rd_lsb +: 5];
            id_ex.reg_wr = valid;
            id_ex.wb_src = proc_pipe_pkg::wb_alu;
            case (funct)
               proc_isa_pkg::funct_sub: id_ex.alu_op = proc_isa_pkg::alu_sub;
               proc_isa_pkg::funct_and: id_ex.alu_op = proc_isa_pkg::alu_and;
               proc_isa_pkg::funct_or:  id_ex.alu_op = proc_isa_pkg::alu_or;
               proc_isa_pkg::funct_xor: id_ex.alu_op = proc_isa_pkg::alu_xor;
               proc_isa_pkg::funct_slt: id_ex.alu_op = proc_isa_pkg::alu_slt;
               default:                 id_ex.alu_op = proc_isa_pkg::alu_add;
            endcase
         end
         proc_isa_pkg::op_addi: begin
            id_ex.rd     = rt;
            id_ex.reg_wr = valid;
            id_ex.wb_src = proc_pipe_pkg::wb_alu;
            id_ex.alusrc = 1'b1;
         end
         proc_isa_pkg::op_lw: begin
            id_ex.rd     = rt;
            id_ex.reg_wr = valid;
            id_ex.wb_src = proc_pipe_pkg::wb_mem;
            id_ex.alusrc = 1'b1;
            id_ex.mem_rd = valid;
         end
         proc_isa_pkg::op_sw: begin
            id_ex.alusrc = 1'b1;
            id_ex.mem_wr = valid;
         end
         proc_isa_pkg::op_beqz: id_ex.br_kind = proc_pipe_pkg::br_eqz;
         proc_isa_pkg::op_bnez: id_ex.br_kind = proc_pipe_pkg::br_nez;
         proc_isa_pkg::op_j:    id_ex.br_kind = proc_pipe_pkg::br_jump;
         proc_isa_pkg::op_halt: id_ex.halt    = valid;
         default: ;
      endcase
   end

endmodule

// ==== hw/fetch.sv ====
`timescale 1ns/1ps

module fetch #(
   parameter logic [31:0] reset_pc = 32'h0000_0000
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        stall,
   input  logic        take_branch,
   input  logic [31:0] branch_addr,
   input  logic [31:0] instruction,
   output logic [31:0] instr_addr,
   output logic [31:0] id_instr,
   output logic [31:0] id_pc_4,
   output logic        id_valid
);

   logic [31:0] pc;
   logic [31:0] pc_4;
   logic        fetch_halt;

   assign instr_addr = pc;
   assign pc_4       = pc + 32'd4;

   // HALT at the current PC pins the PC until a redirect
   assign fetch_halt = instruction[proc_isa_pkg::op_msb:proc_isa_pkg::op_lsb]
                       == proc_isa_pkg::op_halt;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= reset_pc;
      end else if (take_branch) begin
         pc <= branch_addr;
      end else if (!stall && !fetch_halt) begin
         pc <= pc_4;
      end
   end

   // IF/ID register, bubble on a taken branch
   always_ff @(posedge clk) begin
      if (rst || take_branch) begin
         id_valid <= 1'b0;
         id_instr <= proc_isa_pkg::nop_instr;
      end else if (!stall) begin
         id_valid <= 1'b1;
         id_instr <= instruction;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         id_pc_4 <= pc_4;
      end
   end

endmodule

// ==== hw/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     stall,
   input  logic     flush,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     out_valid,
   output payload_t out_data
);

   // Flush beats stall, so a squashed slot never lingers
   always_ff @(posedge clk) begin
      if (rst || flush) begin
         out_valid <= 1'b0;
      end else if (!stall) begin
         out_valid <= in_valid;
      end
   end

   // Payload only matters while valid
   always_ff @(posedge clk) begin
      if (!stall) begin
         out_data <= in_data;
      end
   end

endmodule

// ==== hw/proc_pipe_pkg.sv ====
package proc_pipe_pkg;

   typedef enum logic [1:0] {
      wb_alu,
      wb_mem,
      wb_pc_4,  // reserved for a link write
      wb_none
   } wb_src_t;

   // Source of an EX operand
   typedef enum logic [1:0] {
      fwd_reg,
      fwd_mem,
      fwd_wb
   } fwd_sel_t;

   typedef enum logic [1:0] {
      br_none,
      br_eqz,
      br_nez,
      br_jump
   } br_kind_t;

   // Decode to execute
   typedef struct packed {
      logic [31:0]            op_a;
      logic [31:0]            op_b;
      logic [31:0]            imm;
      proc_isa_pkg::alu_op_t  alu_op;
      logic                   alusrc;
      logic [4:0]             rs;
      logic [4:0]             rt;
      logic [4:0]             rd;
      logic                   reg_wr;
      wb_src_t                wb_src;
      logic                   mem_rd;
      logic                   mem_wr;
      br_kind_t               br_kind;
      logic [31:0]            pc_4;
      logic                   halt;
   } id_ex_t;

   // Execute to memory
   typedef struct packed {
      logic [31:0] alu_result;
      logic [31:0] store_data;
      logic [4:0]  rd;
      logic        reg_wr;
      wb_src_t     wb_src;
      logic        mem_rd;
      logic        mem_wr;
      br_kind_t    br_kind;
      logic [31:0] rs_val;
      logic [31:0] br_target;
      logic        halt;
   } ex_mem_t;

   // Memory to writeback
   typedef struct packed {
      logic [31:0] alu_result;
      logic [4:0]  rd;
      logic        reg_wr;
      wb_src_t     wb_src;
      logic        halt;
   } mem_wb_t;

endpackage

// ==== hw/proc_isa_pkg.sv ====
package proc_isa_pkg;

   // Primary opcodes, R-type first
   typedef enum logic [5:0] {
      op_rtype = 6'd0,
      op_addi  = 6'd1,
      op_lw    = 6'd2,
      op_sw    = 6'd3,
      op_beqz  = 6'd4,
      op_bnez  = 6'd5,
      op_j     = 6'd6,
      op_halt  = 6'd7
   } opcode_t;

   // Function field of R-type instructions, bits [5:0]
   typedef enum logic [5:0] {
      funct_add = 6'd0,
      funct_sub = 6'd1,
      funct_and = 6'd2,
      funct_or  = 6'd3,
      funct_xor = 6'd4,
      funct_slt = 6'd5
   } funct_t;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_slt
   } alu_op_t;

   // Field positions
   localparam int op_msb = 31;
   localparam int op_lsb = 26;
   localparam int rs_lsb = 21;
   localparam int rt_lsb = 16;
   localparam int rd_lsb = 11;

   // ADD r0, r0, r0 which never writes
   localparam logic [31:0] nop_instr = 32'h0000_0000;

endpackage
